// File: ads1292/ads1292_controller.sv
// ADS1292 controller, SPI master
// Puts the chip in RDATAC mode, then reads one 72-bit frame per DRDY fall
`timescale 1ns/10ps
`default_nettype none

module ads1292_controller #(
	parameter int SCLK_HALF = 2  // Clocks per SCLK half period
) (
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_spi_miso,
	input  wire        i_drdy_n,
	ads_host_if.device dev,
	output logic       o_spi_sclk,
	output logic       o_spi_mosi,
	output logic       o_spi_csn,
	output logic       o_ads_start
);
	import khu_sensor_pkg::*;

	localparam int DIV_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
	localparam int BIT_W = $clog2(FRAME_W);

	ads_state_t       state;
	logic [DIV_W-1:0] sclk_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic             cmd_sel;    // 0 SDATAC, 1 RDATAC
	spi_byte_t        cmd_sr;
	ads_frame_t       rx_sr;
	ads_frame_t       frame_q;
	logic             spi_sclk;
	logic             spi_mosi;
	logic             spi_csn;
	logic             ads_start;
	logic             init_done;
	logic             frame_valid;
	logic [2:0]       drdy_sync;  // Two sync stages + edge stage

	logic half_tick;
	logic sclk_rise;
	logic sclk_fall;
	logic last_bit;
	logic drdy_fall;

	//============================================================
	// SCLK timing
	//============================================================
	assign half_tick = (sclk_cnt == DIV_W'(SCLK_HALF - 1));
	assign sclk_rise = !spi_csn && half_tick && !spi_sclk;  // MOSI changes here
	assign sclk_fall = !spi_csn && half_tick && spi_sclk;   // MISO sampled here
	// 8 bits per command, 72 per frame
	assign last_bit  = (state == ADS_CMD) ? (bit_cnt == BIT_W'(BYTE_W - 1))
	                                      : (bit_cnt == BIT_W'(FRAME_W - 1));

	// DRDY is active low and asynchronous
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			drdy_sync <= 3'b111;
		else
			drdy_sync <= {drdy_sync[1:0], i_drdy_n};
	end
	assign drdy_fall = drdy_sync[2] && !drdy_sync[1];

	//============================================================
	// Control FSM and SPI engine
	//============================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= ADS_IDLE;
			sclk_cnt    <= '0;
			bit_cnt     <= '0;
			cmd_sel     <= 1'b0;
			spi_sclk    <= 1'b1;  // SCLK idles high
			spi_mosi    <= 1'b0;
			spi_csn     <= 1'b1;
			ads_start   <= 1'b0;
			init_done   <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			if (init_done)
				ads_start <= dev.run;  // START follows run once set up
			case (state)
				ADS_IDLE: begin
					if (dev.run)
						state <= ADS_CMD;
				end
				ADS_CMD, ADS_READ: begin
					if (spi_csn) begin  // Open a CSN window
						spi_csn  <= 1'b0;
						spi_sclk <= 1'b1;
						sclk_cnt <= '0;
						bit_cnt  <= '0;
						spi_mosi <= (state == ADS_CMD) ? cmd_sr[BYTE_W-1] : 1'b0;
					end else if (half_tick) begin
						sclk_cnt <= '0;
						spi_sclk <= !spi_sclk;
						if (sclk_rise) begin
							bit_cnt  <= bit_cnt + 1'b1;
							spi_mosi <= (state == ADS_CMD) ? cmd_sr[BYTE_W-2] : 1'b0;
							if (last_bit) begin
								spi_csn  <= 1'b1;  // Window ends on last rising SCLK
								spi_mosi <= 1'b0;
								if (state == ADS_READ)
									state <= ADS_DONE;
								else if (cmd_sel)
									state <= ADS_START;
								else
									cmd_sel <= 1'b1;  // Second byte next
							end
						end
					end else begin
						sclk_cnt <= sclk_cnt + 1'b1;
					end
				end
				ADS_START: begin
					ads_start <= 1'b1;
					state     <= ADS_WAIT_DRDY;
				end
				ADS_WAIT_DRDY: begin
					init_done <= 1'b1;  // One cycle after START
					if (dev.run && drdy_fall)
						state <= ADS_READ;
				end
				ADS_DONE: begin
					frame_valid <= 1'b1;  // Cycle after CSN rises
					state       <= ADS_WAIT_DRDY;
				end
				default: state <= ADS_IDLE;
			endcase
		end
	end

	// Command byte, MSB out first
	always_ff @(posedge i_clk) begin
		if (state == ADS_IDLE)
			cmd_sr <= CMD_SDATAC;
		else if (state == ADS_CMD && sclk_rise)
			cmd_sr <= last_bit ? CMD_RDATAC : {cmd_sr[BYTE_W-2:0], 1'b0};
	end

	// Frame capture
	always_ff @(posedge i_clk) begin
		if (state == ADS_READ && sclk_fall)
			rx_sr <= {rx_sr[FRAME_W-2:0], i_spi_miso};
		if (state == ADS_DONE)
			frame_q <= rx_sr;
	end

	assign dev.init_done   = init_done;
	assign dev.busy        = (state == ADS_CMD) || (state == ADS_READ) || (state == ADS_DONE);
	assign dev.frame       = frame_q;
	assign dev.frame_valid = frame_valid;

	assign o_spi_sclk  = spi_sclk;
	assign o_spi_mosi  = spi_mosi;
	assign o_spi_csn   = spi_csn;
	assign o_ads_start = ads_start;

endmodule

`default_nettype wire

// File: common/ads_host_if.sv
// Sensor core to ADS1292 controller link
// Run control down, init status and frames up
`timescale 1ns/10ps
`default_nettype none

interface ads_host_if;
	import khu_sensor_pkg::*;

	logic       run;          // Level from host
	logic       init_done;    // Chip in RDATAC, START high
	logic       busy;         // SPI transfer in progress
	ads_frame_t frame;        // Held until next frame_valid
	logic       frame_valid;  // One-cycle strobe

	modport host (
		output run,
		input  init_done, busy, frame, frame_valid
	);

	modport device (
		input  run,
		output init_done, busy, frame, frame_valid
	);

endinterface

`default_nettype wire

// File: common/khu_sensor_pkg.sv
// khu_sensor shared definitions
// Frame layout, word packing, ADS1292 opcodes and controller states
`default_nettype none

package khu_sensor_pkg;

	//============================================================
	// Widths
	//============================================================
	localparam int FRAME_W = 72;  // Status + two channels
	localparam int CH_W    = 24;  // One ADS1292 channel
	localparam int WORD_W  = 32;  // Word sent to the PC
	localparam int BYTE_W  = 8;
	localparam int PACK_W  = 16;  // Kept bits per channel

	typedef logic [FRAME_W-1:0] ads_frame_t;
	typedef logic [WORD_W-1:0]  uart_word_t;
	typedef logic [BYTE_W-1:0]  spi_byte_t;

	//============================================================
	// Frame fields, MSB first on the wire
	//============================================================
	// [71:48] status, [47:24] channel 1, [23:0] channel 2
	localparam int CH1_MSB = 2*CH_W - 1;
	localparam int CH2_MSB = CH_W - 1;

	// ADS1292 SPI opcodes
	localparam spi_byte_t CMD_SDATAC = 8'h11;  // Stop continuous read
	localparam spi_byte_t CMD_RDATAC = 8'h10;  // Start continuous read

	// Controller FSM
	typedef enum logic [2:0] {
		ADS_IDLE,       // After reset, waiting for run
		ADS_CMD,        // Shifting a command byte
		ADS_START,      // Raise START
		ADS_WAIT_DRDY,  // Armed, waiting for DRDY fall
		ADS_READ,       // Clocking out a 72-bit frame
		ADS_DONE        // Publish the frame
	} ads_state_t;

endpackage

`default_nettype wire

// File: hdl/khu_sensor_top.sv
// khu_sensor top level
// ADS1292 frames in over SPI, packed words out over UART
`timescale 1ns/10ps
`default_nettype none

module khu_sensor_top #(
	parameter int CLKS_PER_BIT = 8,  // UART bit time in clocks
	parameter int SCLK_HALF    = 2   // SPI half period in clocks
) (
	input  wire  i_clk,
	input  wire  i_rst_n,
	input  wire  i_run,
	input  wire  i_spi_miso,
	input  wire  i_drdy_n,
	output logic o_txd,
	output logic o_spi_sclk,
	output logic o_spi_mosi,
	output logic o_spi_csn,
	output logic o_ads_start,
	output logic o_init_done,
	output logic o_overrun,
	output logic o_core_busy
);
	import khu_sensor_pkg::*;

	//============================================================
	// Internal connection
	//============================================================
	uart_word_t w_tx_word;
	logic       w_tx_valid;
	logic       w_tx_ready;

	ads_host_if u_ads_if ();

	assign o_init_done = u_ads_if.init_done;

	ads1292_controller #(
		.SCLK_HALF (SCLK_HALF)
	) u_ads1292_controller (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_spi_miso  (i_spi_miso),
		.i_drdy_n    (i_drdy_n),   // Active low data ready
		.dev         (u_ads_if.device),
		.o_spi_sclk  (o_spi_sclk),
		.o_spi_mosi  (o_spi_mosi),
		.o_spi_csn   (o_spi_csn),
		.o_ads_start (o_ads_start)
	);

	sensor_core u_sensor_core (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_run       (i_run),
		.i_tx_ready  (w_tx_ready),
		.host        (u_ads_if.host),
		.o_tx_word   (w_tx_word),
		.o_tx_valid  (w_tx_valid),
		.o_overrun   (o_overrun),
		.o_core_busy (o_core_busy)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_word  (w_tx_word),
		.i_valid (w_tx_valid),
		.o_ready (w_tx_ready),
		.o_txd   (o_txd)      // To PC
	);

endmodule

`default_nettype wire

// File: hdl/sensor_core.sv
// Sensor core
// Run control, frame to word packing, one-word buffer, overrun flag
`timescale 1ns/10ps
`default_nettype none

module sensor_core (
	input  wire                        i_clk,
	input  wire                        i_rst_n,
	input  wire                        i_run,
	input  wire                        i_tx_ready,
	ads_host_if.host                   host,
	output khu_sensor_pkg::uart_word_t o_tx_word,
	output logic                       o_tx_valid,
	output logic                       o_overrun,
	output logic                       o_core_busy
);
	import khu_sensor_pkg::*;

	logic       run_q;
	logic       buf_full;
	uart_word_t buf_word;
	uart_word_t pack_word;
	logic       frame_in;
	logic       tx_xfer;

	//============================================================
	// Run control
	//============================================================
	// Run changes only between SPI transfers
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			run_q <= 1'b0;
		else if (!host.busy)
			run_q <= i_run;
	end
	assign host.run = run_q;

	//============================================================
	// Packing and buffer
	//============================================================
	// Top 16 bits of ch1 in upper half, ch2 in lower half
	assign pack_word = {host.frame[CH1_MSB -: PACK_W], host.frame[CH2_MSB -: PACK_W]};
	assign frame_in  = host.frame_valid && host.init_done;
	assign tx_xfer   = buf_full && i_tx_ready;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			buf_full  <= 1'b0;
			o_overrun <= 1'b0;
		end else begin
			if (tx_xfer)
				buf_full <= 1'b0;  // Word taken by UART
			if (frame_in) begin
				if (!buf_full)
					buf_full <= 1'b1;
				else
					o_overrun <= 1'b1;  // Sticky, frame dropped
			end
		end
	end

	// Word payload
	always_ff @(posedge i_clk) begin
		if (frame_in && !buf_full)
			buf_word <= pack_word;
	end

	assign o_tx_word   = buf_word;
	assign o_tx_valid  = buf_full;
	assign o_core_busy = buf_full || !i_tx_ready;

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
// UART transmitter, 8N1
// Sends one 32-bit word as four bytes, MSB byte first
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  wire                       i_clk,
	input  wire                       i_rst_n,
	input  khu_sensor_pkg::uart_word_t i_word,
	input  wire                       i_valid,
	output logic                      o_ready,
	output logic                      o_txd
);
	import khu_sensor_pkg::*;

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	logic             busy;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
	logic [1:0]       byte_idx;
	uart_word_t       word_sr;
	spi_byte_t        tx_byte;
	logic             bit_end;

	assign tx_byte = word_sr[WORD_W-1 -: BYTE_W];  // Current byte, top of word
	assign bit_end = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign o_ready = !busy;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_idx  <= '0;
			byte_idx <= '0;
			o_txd    <= 1'b1;  // Line idles high
		end else if (!busy) begin
			if (i_valid) begin
				busy     <= 1'b1;
				baud_cnt <= '0;
				bit_idx  <= '0;
				byte_idx <= '0;
				o_txd    <= 1'b0;  // First start bit
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_idx == 4'd9) begin
				if (byte_idx == 2'd3) begin
					busy <= 1'b0;  // 40 bit times done
				end else begin
					byte_idx <= byte_idx + 1'b1;
					bit_idx  <= '0;
					o_txd    <= 1'b0;
				end
			end else begin
				bit_idx <= bit_idx + 1'b1;
				o_txd   <= (bit_idx == 4'd8) ? 1'b1 : tx_byte[bit_idx[2:0]];  // LSB first
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// Payload, next byte moves up after each stop bit
	always_ff @(posedge i_clk) begin
		if (!busy && i_valid)
			word_sr <= i_word;
		else if (busy && bit_end && bit_idx == 4'd9)
			word_sr <= {word_sr[WORD_W-BYTE_W-1:0], {BYTE_W{1'b0}}};
	end

endmodule

`default_nettype wire

// File: khu_sensor.f
common/khu_sensor_pkg.sv
common/ads_host_if.sv
ads1292/ads1292_controller.sv
hdl/uart_tx.sv
hdl/sensor_core.sv
hdl/khu_sensor_top.sv
tests/tb_khu_sensor_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the khu_sensor testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f khu_sensor.f --top-module tb_khu_sensor_top -o sim_tb

# The log decides the result
./obj_dir/sim_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

// File: tests/tb_khu_sensor_top.sv
// Testbench for the khu_sensor top level
// ADS1292 bus model, UART byte monitor and a table of frames with their packed words
`timescale 1ns/10ps
`default_nettype none

module tb_khu_sensor_top;
	import khu_sensor_pkg::*;

	//============================================================
	// Timing and table
	//============================================================
	localparam int CLKS_PER_BIT = 16;  // UART word outlasts two frame reads
	localparam int SCLK_HALF    = 2;
	localparam int NUM_VEC      = 4;
	localparam int DRDY_LOW     = 3;   // DRDY pulse width in clocks
	localparam int FRAME_CLKS   = 72*2*SCLK_HALF + 40*CLKS_PER_BIT;
	localparam int NUM_FRAMES   = NUM_VEC + 3 + 3;  // Table, run off, overrun
	localparam int WATCHDOG_CLKS = NUM_FRAMES*FRAME_CLKS*4 + 2000;

	typedef struct packed {
		ads_frame_t frame;
		uart_word_t word;
	} frame_vec_t;

	// Word = ch1[23:8], ch2[23:8]
	frame_vec_t vec_tab [NUM_VEC] = '{
		'{72'hC00000_123456_ABCDEF, 32'h1234_ABCD},
		'{72'hC00000_7FFFFF_800000, 32'h7FFF_8000},
		'{72'hC00001_00FF00_FF00FF, 32'h00FF_FF00},
		'{72'hC0A5A5_5A5A5A_A5A5A5, 32'h5A5A_A5A5}
	};

	logic i_clk;
	logic i_rst_n;
	logic i_run;
	logic i_spi_miso;
	logic i_drdy_n;
	wire  o_txd;
	wire  o_spi_sclk;
	wire  o_spi_mosi;
	wire  o_spi_csn;
	wire  o_ads_start;
	wire  o_init_done;
	wire  o_overrun;
	wire  o_core_busy;

	ads_frame_t model_frame;   // Frame the chip returns on the next read
	ads_frame_t shift_frame;
	spi_byte_t  mosi_sr;
	spi_byte_t  rx_byte;
	spi_byte_t  mosi_q [$];    // Bytes seen by the chip
	spi_byte_t  uart_q [$];    // Bytes seen by the PC
	int         mosi_bits;
	int         csn_windows;
	logic       csn_q;
	logic       sclk_q;
	int         windows_before;

	khu_sensor_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.SCLK_HALF    (SCLK_HALF)
	) u_khu_sensor_top (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_run       (i_run),
		.i_spi_miso  (i_spi_miso),
		.i_drdy_n    (i_drdy_n),
		.o_txd       (o_txd),
		.o_spi_sclk  (o_spi_sclk),
		.o_spi_mosi  (o_spi_mosi),
		.o_spi_csn   (o_spi_csn),
		.o_ads_start (o_ads_start),
		.o_init_done (o_init_done),
		.o_overrun   (o_overrun),
		.o_core_busy (o_core_busy)
	);

	always #5 i_clk = ~i_clk;  // 10 ns period

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
	                     input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s, got %h expected %h", $time, what, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "compare failed");
		end
	endtask

	// Compare four monitor bytes from base with one word in MSB-first order
	task automatic check_word(input uart_word_t exp_word, input int base, input string what);
		for (int b = 0; b < 4; b++)
			check(32'(uart_q[base + b]), 32'(exp_word[WORD_W-1-8*b -: 8]), what);
	endtask

	task automatic pulse_drdy();  // Entered on a falling clock edge
		i_drdy_n = 1'b0;
		repeat (DRDY_LOW) @(negedge i_clk);
		i_drdy_n = 1'b1;
	endtask

	task automatic wait_csn_window();
		while (o_spi_csn) @(negedge i_clk);
		while (!o_spi_csn) @(negedge i_clk);  // Returns once CSN is back high
	endtask

	//============================================================
	// ADS1292 bus model looking at SPI half a clock after each edge
	//============================================================
	always @(negedge i_clk) begin
		if (!o_spi_csn) begin
			if (csn_q) begin  // Window opens with the first bit ready before the first fall
				shift_frame = model_frame;
				i_spi_miso  = shift_frame[FRAME_W-1];
				shift_frame = shift_frame << 1;
				mosi_bits   = 0;
				csn_windows = csn_windows + 1;
			end else if (o_spi_sclk && !sclk_q) begin
				i_spi_miso  = shift_frame[FRAME_W-1];  // Next bit on rising SCLK
				shift_frame = shift_frame << 1;
			end else if (!o_spi_sclk && sclk_q) begin
				mosi_sr   = {mosi_sr[BYTE_W-2:0], o_spi_mosi};
				mosi_bits = mosi_bits + 1;
				if (mosi_bits == BYTE_W) begin
					mosi_q.push_back(mosi_sr);
					mosi_bits = 0;
				end
			end
		end
		csn_q  = o_spi_csn;
		sclk_q = o_spi_sclk;
	end

	// UART monitor sampling mid-bit
	always begin
		@(negedge i_clk);
		if (i_rst_n && !o_txd) begin
			repeat (CLKS_PER_BIT/2) @(negedge i_clk);
			check(32'(o_txd), 32'd0, "UART start bit");
			for (int b = 0; b < 8; b++) begin
				repeat (CLKS_PER_BIT) @(negedge i_clk);
				rx_byte[b] = o_txd;  // LSB first
			end
			repeat (CLKS_PER_BIT) @(negedge i_clk);
			check(32'(o_txd), 32'd1, "UART stop bit");
			uart_q.push_back(rx_byte);
		end
	end

	initial begin
		repeat (WATCHDOG_CLKS) @(posedge i_clk);
		$display("Watchdog expired: the DUT stopped responding before the tests finished");
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	//============================================================
	// Test sequence
	//============================================================
	initial begin
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_run = 1'b0;
		i_spi_miso = 1'b0;
		i_drdy_n = 1'b1;
		model_frame = '0;
		shift_frame = '0;
		mosi_sr = '0;
		mosi_bits = 0;
		csn_windows = 0;
		csn_q = 1'b1;
		sclk_q = 1'b1;
		void'($urandom(32'h9a2e));
		repeat (3) @(negedge i_clk);
		i_rst_n = 1'b1;

		// Reset values
		check(32'(o_spi_csn), 32'd1, "CSN after reset");
		check(32'(o_spi_sclk), 32'd1, "SCLK after reset");
		check(32'(o_spi_mosi), 32'd0, "MOSI after reset");
		check(32'(o_txd), 32'd1, "TXD after reset");
		check(32'(o_ads_start), 32'd0, "START after reset");
		check(32'(o_init_done), 32'd0, "init_done after reset");
		check(32'(o_overrun), 32'd0, "overrun after reset");
		check(32'(o_core_busy), 32'd0, "core busy after reset");

		// Start-up commands
		repeat (2) @(negedge i_clk);
		i_run = 1'b1;
		while (!o_init_done) @(negedge i_clk);
		check(32'(mosi_q.size()), 32'd2, "command byte count");
		check(32'(mosi_q[0]), 32'h11, "first command");
		check(32'(mosi_q[1]), 32'h10, "second command");
		check(32'(o_ads_start), 32'd1, "START after start-up");

		// One frame at a time with the UART idle in between
		for (int i = 0; i < NUM_VEC; i++) begin
			repeat (5 + ($urandom % 20)) @(negedge i_clk);
			uart_q.delete();
			model_frame = vec_tab[i].frame;
			pulse_drdy();
			while (uart_q.size() < 4) @(negedge i_clk);
			check_word(vec_tab[i].word, 0, "packed word");
			check(32'(o_core_busy), 32'd1, "core busy while UART sends");
			while (o_core_busy) @(negedge i_clk);
			check(32'(o_overrun), 32'd0, "overrun on spaced frames");
		end

		// DRDY ignored while run is off
		i_run = 1'b0;
		while (o_ads_start) @(negedge i_clk);
		windows_before = csn_windows;
		uart_q.delete();
		for (int k = 0; k < 3; k++) begin
			repeat (20) @(negedge i_clk);
			pulse_drdy();
		end
		repeat (2*72*2*SCLK_HALF) @(negedge i_clk);
		check(32'(csn_windows), 32'(windows_before), "CSN windows with run off");
		check(32'(uart_q.size()), 32'd0, "UART bytes with run off");
		check(32'(o_ads_start), 32'd0, "START with run off");
		i_run = 1'b1;
		while (!o_ads_start) @(negedge i_clk);

		// Three back-to-back frames where the third overflows
		uart_q.delete();
		for (int k = 0; k < 3; k++) begin
			model_frame = vec_tab[k].frame;
			pulse_drdy();
			wait_csn_window();
		end
		while (uart_q.size() < 8) @(negedge i_clk);
		while (o_core_busy) @(negedge i_clk);
		repeat (40*CLKS_PER_BIT + 50) @(negedge i_clk);  // Room for a third word
		check(32'(uart_q.size()), 32'd8, "bytes after overrun");
		check_word(vec_tab[0].word, 0, "first back-to-back word");
		check_word(vec_tab[1].word, 4, "second back-to-back word");
		check(32'(o_overrun), 32'd1, "overrun flag");

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire
